// ==== rtl/bounce_pkg.sv ====
// Game types, control and status structs, play-field limits, start tables, segment codes
package bounce_pkg;

    typedef logic [7:0] coord_x_t;
    typedef logic [6:0] coord_y_t;
    typedef logic [1:0] lives_t;
    typedef logic [7:0] score_t;
    // Active-low segments with bit 6 as segment g
    typedef logic [6:0] seg7_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } point_t;

    // Same bit order as KEY[3:0]
    typedef struct packed {
        logic left;
        logic down;
        logic up;
        logic right;
    } dir_t;

    typedef enum logic [1:0] {
        SPEED_SLOW,
        SPEED_MID,
        SPEED_FAST
    } speed_t;

    typedef enum logic {
        PLAYING,
        OVER
    } game_state_t;

    localparam int NUM_BEES = 6;

    typedef struct packed {
        dir_t                player_dir;
        logic [NUM_BEES-1:0] bee_enable;
        speed_t              speed;
        logic                resume;
    } ctrl_t;

    typedef struct packed {
        lives_t lives;
        logic   over;
    } status_t;

    // Reaching a border bound counts as a wall hit
    localparam coord_x_t X_MIN = 8'd4;
    localparam coord_x_t X_MAX = 8'd152;
    localparam coord_y_t Y_MIN = 7'd24;
    localparam coord_y_t Y_MAX = 7'd112;

    localparam int unsigned HIT_RADIUS = 3;

    localparam point_t PLAYER_START = '{x: 8'd80, y: 7'd60};
    localparam lives_t LIVES_START  = 2'd3;

    localparam point_t BEE_START_POS [NUM_BEES] = '{
        '{x: 8'd30,  y: 7'd48},
        '{x: 8'd34,  y: 7'd74},
        '{x: 8'd103, y: 7'd89},
        '{x: 8'd67,  y: 7'd100},
        '{x: 8'd108, y: 7'd56},
        '{x: 8'd67,  y: 7'd29}
    };

    localparam dir_t BEE_START_DIR [NUM_BEES] = '{
        4'b1100, 4'b1100, 4'b0011, 4'b0101, 4'b0101, 4'b1100
    };

    localparam seg7_t SEG_BLANK = 7'b1111111;

    // Hex digits 0 to F
    localparam seg7_t SEG_HEX [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    // "GAME OVEr" read from HEX7 down to HEX0 with entry 0 on HEX0
    localparam seg7_t SEG_OVER [8] = '{
        7'b0101111, 7'b0000110, 7'b1000001, 7'b1000000,
        7'b0000110, 7'b1101010, 7'b0001000, 7'b1000010
    };

endpackage

// ==== rtl/game_tick.sv ====
// Game tick rate divider with speed-selected reload period
`timescale 1ns/1ps

module game_tick #(
    parameter int TICK_SLOW = 1000000,
    parameter int TICK_MID  = 750000,
    parameter int TICK_FAST = 500000
) (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  bounce_pkg::speed_t speed,
    output logic               tick
);
    import bounce_pkg::*;

    localparam int MAX_A  = (TICK_SLOW > TICK_MID) ? TICK_SLOW : TICK_MID;
    localparam int MAX_P  = (MAX_A > TICK_FAST) ? MAX_A : TICK_FAST;
    localparam int CW     = $clog2(MAX_P + 1);

    logic [CW-1:0] count;
    int            period;

    always_comb
    begin
        case (speed)
            SPEED_FAST: period = TICK_FAST;
            SPEED_MID:  period = TICK_MID;
            default:    period = TICK_SLOW;
        endcase
    end

    // Speed is only looked at on reload
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
            count <= CW'(TICK_SLOW - 1);
        else if (count == '0)
            count <= CW'(period - 1);
        else
            count <= count - 1'b1;
    end

    assign tick = (count == '0);

endmodule

// ==== rtl/control_decode.sv ====
// Control decoder for keys, bee enables, speed select and resume edge
`timescale 1ns/1ps

module control_decode (
    input  logic              CLOCK_50,
    input  logic              rst_n,
    input  logic [3:0]        KEY,
    input  logic [17:0]       SW,
    output bounce_pkg::ctrl_t ctrl
);
    import bounce_pkg::*;

    speed_t speed_next;
    logic   sw15_q;

    // 00 slow, either switch mid, both fast
    always_comb
    begin
        case (SW[17:16])
            2'b00:   speed_next = SPEED_SLOW;
            2'b11:   speed_next = SPEED_FAST;
            default: speed_next = SPEED_MID;
        endcase
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
        begin
            ctrl   <= '0;
            sw15_q <= 1'b0;
        end
        else
        begin
            // Keys are active low
            ctrl.player_dir <= dir_t'(~KEY);
            ctrl.bee_enable <= SW[NUM_BEES-1:0];
            ctrl.speed      <= speed_next;
            ctrl.resume     <= SW[15] & ~sw15_q;
            sw15_q          <= SW[15];
        end
    end

endmodule

// ==== rtl/sprite_motion.sv ====
// Player and bee position registers with bee bounce and player respawn
`timescale 1ns/1ps

module sprite_motion (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                tick,
    input  logic                respawn,
    input  bounce_pkg::ctrl_t   ctrl,
    input  bounce_pkg::status_t status,
    output bounce_pkg::point_t  player_pos,
    output bounce_pkg::point_t  bee_pos [bounce_pkg::NUM_BEES]
);
    import bounce_pkg::*;

    dir_t bee_dir      [NUM_BEES];
    dir_t bee_dir_next [NUM_BEES];

    // One pixel per set flag
    function automatic point_t step_point(point_t p, dir_t d);
        point_t n;
        n.x = p.x + coord_x_t'(d.right) - coord_x_t'(d.left);
        n.y = p.y + coord_y_t'(d.down) - coord_y_t'(d.up);
        return n;
    endfunction

    // Turn away from whichever border the bee sits on
    function automatic dir_t bounce_dir(point_t p, dir_t d);
        dir_t n;
        n = d;
        if (p.x >= X_MAX)
        begin
            n.left  = 1'b1;
            n.right = 1'b0;
        end
        else if (p.x <= X_MIN)
        begin
            n.left  = 1'b0;
            n.right = 1'b1;
        end
        if (p.y >= Y_MAX)
        begin
            n.down = 1'b0;
            n.up   = 1'b1;
        end
        else if (p.y <= Y_MIN)
        begin
            n.down = 1'b1;
            n.up   = 1'b0;
        end
        return n;
    endfunction

    always_comb
    begin
        for (int i = 0; i < NUM_BEES; i++)
            bee_dir_next[i] = bounce_dir(bee_pos[i], bee_dir[i]);
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
            player_pos <= PLAYER_START;
        else if (tick)
        begin
            if (respawn)
                player_pos <= PLAYER_START;
            else if (!status.over)
                player_pos <= step_point(player_pos, ctrl.player_dir);
        end
    end

    // Bees keep flying even when disabled or after game over
    always_ff @(posedge CLOCK_50)
    begin
        for (int i = 0; i < NUM_BEES; i++)
        begin
            if (!rst_n)
            begin
                bee_pos[i] <= BEE_START_POS[i];
                bee_dir[i] <= BEE_START_DIR[i];
            end
            else if (tick)
            begin
                bee_dir[i] <= bee_dir_next[i];
                bee_pos[i] <= step_point(bee_pos[i], bee_dir_next[i]);
            end
        end
    end

endmodule

// ==== rtl/hit_and_lives.sv ====
// Collision detection, lives counter and playing/over FSM
`timescale 1ns/1ps

module hit_and_lives (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                tick,
    input  bounce_pkg::ctrl_t   ctrl,
    input  bounce_pkg::point_t  player_pos,
    input  bounce_pkg::point_t  bee_pos [bounce_pkg::NUM_BEES],
    output logic                respawn,
    output bounce_pkg::status_t status
);
    import bounce_pkg::*;

    game_state_t state;
    lives_t      lives;
    logic        wall_hit;
    logic        bee_hit;

    assign wall_hit = (player_pos.x >= X_MAX) || (player_pos.x <= X_MIN)
                   || (player_pos.y >= Y_MAX) || (player_pos.y <= Y_MIN);

    always_comb
    begin : bee_check
        coord_x_t dx;
        coord_y_t dy;
        bee_hit = 1'b0;
        for (int i = 0; i < NUM_BEES; i++)
        begin
            dx = (player_pos.x >= bee_pos[i].x) ? player_pos.x - bee_pos[i].x
                                                : bee_pos[i].x - player_pos.x;
            dy = (player_pos.y >= bee_pos[i].y) ? player_pos.y - bee_pos[i].y
                                                : bee_pos[i].y - player_pos.y;
            if (ctrl.bee_enable[i] && dx <= HIT_RADIUS && dy <= HIT_RADIUS)
                bee_hit = 1'b1;
        end
    end

    // Collisions don't count once the game is over
    assign respawn = tick && (wall_hit || bee_hit) && (state == PLAYING);

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
        begin
            state <= PLAYING;
            lives <= LIVES_START;
        end
        else
        begin
            case (state)
                PLAYING:
                    if (respawn)
                    begin
                        if (lives != '0)
                            lives <= lives - 1'b1;
                        else
                        begin
                            state <= OVER;
                            lives <= LIVES_START;
                        end
                    end
                default:
                    if (ctrl.resume)
                        state <= PLAYING;
            endcase
        end
    end

    assign status.lives = lives;
    assign status.over  = (state == OVER);

endmodule

// ==== rtl/scoreboard_display.sv ====
// Score and high score counters with seven-segment display encoding
`timescale 1ns/1ps

module scoreboard_display #(
    parameter int SCORE_INTERVAL = 100
) (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic                tick,
    input  bounce_pkg::status_t status,
    output bounce_pkg::seg7_t   HEX0,
    output bounce_pkg::seg7_t   HEX1,
    output bounce_pkg::seg7_t   HEX2,
    output bounce_pkg::seg7_t   HEX3,
    output bounce_pkg::seg7_t   HEX4,
    output bounce_pkg::seg7_t   HEX5,
    output bounce_pkg::seg7_t   HEX6,
    output bounce_pkg::seg7_t   HEX7
);
    import bounce_pkg::*;

    localparam int PW = $clog2(SCORE_INTERVAL + 1);

    logic [PW-1:0] prescale;
    score_t        score;
    score_t        high_score;
    seg7_t         seg [8];

    // Score restarts from zero for as long as the game is over
    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n || status.over)
        begin
            prescale <= '0;
            score    <= '0;
        end
        else if (tick)
        begin
            if (prescale == PW'(SCORE_INTERVAL - 1))
            begin
                prescale <= '0;
                score    <= score + 1'b1;
            end
            else
                prescale <= prescale + 1'b1;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n)
            high_score <= '0;
        else if (score > high_score)
            high_score <= score;
    end

    always_comb
    begin
        if (status.over)
        begin
            for (int i = 0; i < 8; i++)
                seg[i] = SEG_OVER[i];
        end
        else
        begin
            seg[0] = SEG_HEX[{2'b00, status.lives}];
            seg[1] = SEG_BLANK;
            seg[2] = SEG_BLANK;
            seg[3] = SEG_BLANK;
            seg[4] = SEG_HEX[score[3:0]];
            seg[5] = SEG_HEX[score[7:4]];
            seg[6] = SEG_HEX[high_score[3:0]];
            seg[7] = SEG_HEX[high_score[7:4]];
        end
    end

    assign HEX0 = seg[0];
    assign HEX1 = seg[1];
    assign HEX2 = seg[2];
    assign HEX3 = seg[3];
    assign HEX4 = seg[4];
    assign HEX5 = seg[5];
    assign HEX6 = seg[6];
    assign HEX7 = seg[7];

endmodule

// ==== rtl/bounce_top.sv ====
// Top level of the bee dodge game logic
`timescale 1ns/1ps

module bounce_top #(
    parameter int TICK_SLOW      = 1000000,
    parameter int TICK_MID       = 750000,
    parameter int TICK_FAST      = 500000,
    parameter int SCORE_INTERVAL = 100
) (
    input  logic                CLOCK_50,
    input  logic                rst_n,
    input  logic [3:0]          KEY,
    input  logic [17:0]         SW,
    output bounce_pkg::seg7_t   HEX0,
    output bounce_pkg::seg7_t   HEX1,
    output bounce_pkg::seg7_t   HEX2,
    output bounce_pkg::seg7_t   HEX3,
    output bounce_pkg::seg7_t   HEX4,
    output bounce_pkg::seg7_t   HEX5,
    output bounce_pkg::seg7_t   HEX6,
    output bounce_pkg::seg7_t   HEX7,
    output bounce_pkg::point_t  player_pos,
    output bounce_pkg::point_t  bee_pos [bounce_pkg::NUM_BEES],
    output bounce_pkg::status_t status
);
    import bounce_pkg::*;

    ctrl_t ctrl;
    logic  tick;
    logic  respawn;

    // Decode
    control_decode u_decode (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .KEY      (KEY),
        .SW       (SW),
        .ctrl     (ctrl)
    );

    game_tick #(
        .TICK_SLOW (TICK_SLOW),
        .TICK_MID  (TICK_MID),
        .TICK_FAST (TICK_FAST)
    ) u_tick (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .speed    (ctrl.speed),
        .tick     (tick)
    );

    // Execute
    sprite_motion u_motion (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .tick       (tick),
        .respawn    (respawn),
        .ctrl       (ctrl),
        .status     (status),
        .player_pos (player_pos),
        .bee_pos    (bee_pos)
    );

    hit_and_lives u_hits (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .tick       (tick),
        .ctrl       (ctrl),
        .player_pos (player_pos),
        .bee_pos    (bee_pos),
        .respawn    (respawn),
        .status     (status)
    );

    // Result
    scoreboard_display #(
        .SCORE_INTERVAL (SCORE_INTERVAL)
    ) u_score (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .tick     (tick),
        .status   (status),
        .HEX0     (HEX0),
        .HEX1     (HEX1),
        .HEX2     (HEX2),
        .HEX3     (HEX3),
        .HEX4     (HEX4),
        .HEX5     (HEX5),
        .HEX6     (HEX6),
        .HEX7     (HEX7)
    );

endmodule

// ==== testbench/tb_table.svh ====
// Step table type and data, hex digit codes, player and bee reference models
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

typedef struct packed {
    logic [3:0]  key;
    logic [17:0] sw;
    int          ticks;
    int          x;
    int          y;
    int          lives;
    int          over;
    int          score;
    int          high;
} step_t;

localparam int NUM_STEPS = 15;

// Columns: KEY, SW, ticks, then expected x, y, lives, over, score, high score
// KEY is active low: bit 3 left, bit 2 down, bit 1 up, bit 0 right
localparam step_t STEPS [NUM_STEPS] = '{
    '{4'b1110, 18'h00000,  5,  85, 60, 3, 0,  1,  1},
    '{4'b1101, 18'h00000,  4,  85, 56, 3, 0,  2,  2},
    '{4'b0011, 18'h00000,  3,  82, 59, 3, 0,  3,  3},
    '{4'b1111, 18'h00000,  2,  82, 59, 3, 0,  3,  3},
    '{4'b1110, 18'h00000, 70, 152, 59, 3, 0, 21, 21},
    '{4'b1110, 18'h00000,  1,  80, 60, 2, 0, 21, 21},
    '{4'b1101, 18'h00000, 36,  80, 24, 2, 0, 30, 30},
    '{4'b1101, 18'h00000,  1,  80, 60, 1, 0, 30, 30},
    '{4'b0111, 18'h00000, 76,   4, 60, 1, 0, 49, 49},
    '{4'b0111, 18'h00000,  1,  80, 60, 0, 0, 49, 49},
    '{4'b1011, 18'h00000, 52,  80, 112, 0, 0, 62, 62},
    '{4'b1011, 18'h00000,  1,  80, 60, 3, 1,  0, 63},
    '{4'b1110, 18'h00000,  3,  80, 60, 3, 1,  0, 63},
    '{4'b1111, 18'h08000,  4,  80, 60, 3, 0,  1, 63},
    '{4'b1110, 18'h08000,  3,  83, 60, 3, 0,  1, 63}
};

// Active-low digits 0 to F, bit 6 is segment g
localparam logic [6:0] HEX_CODES [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
};

localparam int TICK_PERIODS [4] = '{6, 4, 4, 2};

function automatic point_t player_step(point_t p, logic [3:0] key);
    point_t n;
    n.x = coord_x_t'(int'(p.x) + int'(!key[0]) - int'(!key[3]));
    n.y = coord_y_t'(int'(p.y) + int'(!key[2]) - int'(!key[1]));
    return n;
endfunction

// A bee turns at a border first, then steps
function automatic dir_t model_turn(point_t p, dir_t d);
    dir_t n;
    n = d;
    if (p.x >= X_MAX)
        {n.left, n.right} = 2'b10;
    else if (p.x <= X_MIN)
        {n.left, n.right} = 2'b01;
    if (p.y >= Y_MAX)
        {n.up, n.down} = 2'b10;
    else if (p.y <= Y_MIN)
        {n.up, n.down} = 2'b01;
    return n;
endfunction

function automatic point_t model_move(point_t p, dir_t d);
    point_t n;
    n.x = coord_x_t'(int'(p.x) + int'(d.right) - int'(d.left));
    n.y = coord_y_t'(int'(p.y) + int'(d.down) - int'(d.up));
    return n;
endfunction

function automatic logic within_radius(point_t a, point_t b);
    int dx;
    int dy;
    dx = int'(a.x) - int'(b.x);
    dy = int'(a.y) - int'(b.y);
    return (dx <= 3 && dx >= -3 && dy <= 3 && dy >= -3);
endfunction

`endif

// ==== testbench/bounce_tb.sv ====
// Testbench for the bee dodge game: step table, random walk, bee hits, speed spacing
`timescale 1ns/1ps

module bounce_tb;
    import bounce_pkg::*;
    `include "tb_table.svh"

    localparam int TIMEOUT_CYCLES = 40;

    logic        CLOCK_50;
    logic        rst_n;
    logic [3:0]  KEY;
    logic [17:0] SW;
    seg7_t       HEX0, HEX1, HEX2, HEX3, HEX4, HEX5, HEX6, HEX7;
    point_t      player_pos;
    point_t      bee_pos [NUM_BEES];
    status_t     status;

    point_t      exp_player;
    int          exp_lives;
    point_t      m_bee_pos [NUM_BEES];
    dir_t        m_bee_dir [NUM_BEES];
    int          errors;
    int          tests;
    int          failed_tests;
    int          start_err;
    int          cycles;
    logic [31:0] rng;
    logic [3:0]  keys;

    bounce_top #(
        .TICK_SLOW      (6),
        .TICK_MID       (4),
        .TICK_FAST      (2),
        .SCORE_INTERVAL (4)
    ) dut0 (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .KEY        (KEY),
        .SW         (SW),
        .HEX0       (HEX0),
        .HEX1       (HEX1),
        .HEX2       (HEX2),
        .HEX3       (HEX3),
        .HEX4       (HEX4),
        .HEX5       (HEX5),
        .HEX6       (HEX6),
        .HEX7       (HEX7),
        .player_pos (player_pos),
        .bee_pos    (bee_pos),
        .status     (status)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Digit value shown by a segment code, -1 if none
    function automatic int seg_digit(input seg7_t s);
        int d;
        d = -1;
        for (int i = 0; i < 16; i++)
            if (HEX_CODES[i] == s)
                d = i;
        return d;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAIL time=%0t %s actual=%0d expected=%0d", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int first_err);
        tests++;
        if (errors != first_err)
        begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - first_err);
        end
        else
            $display("%s: ok", name);
    endtask

    // Waits for one tick, steps the bee model and compares all bees
    task automatic wait_one_tick(output int n_cycles);
        int n;
        n = 0;
        while (dut0.tick !== 1'b1 && n < TIMEOUT_CYCLES)
        begin
            @(negedge CLOCK_50);
            n++;
        end
        if (dut0.tick !== 1'b1)
        begin
            $display("Timeout: no game tick within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
        for (int i = 0; i < NUM_BEES; i++)
        begin
            m_bee_dir[i] = model_turn(m_bee_pos[i], m_bee_dir[i]);
            m_bee_pos[i] = model_move(m_bee_pos[i], m_bee_dir[i]);
        end
        @(negedge CLOCK_50);
        n_cycles = n + 1;
        for (int i = 0; i < NUM_BEES; i++)
        begin
            check_value($sformatf("bee_pos[%0d].x", i), bee_pos[i].x, m_bee_pos[i].x);
            check_value($sformatf("bee_pos[%0d].y", i), bee_pos[i].y, m_bee_pos[i].y);
        end
    endtask

    task automatic check_state(input int x, input int y, input int lives, input int over);
        seg7_t hx [8];
        hx = '{HEX0, HEX1, HEX2, HEX3, HEX4, HEX5, HEX6, HEX7};
        check_value("player_pos.x", player_pos.x, x);
        check_value("player_pos.y", player_pos.y, y);
        check_value("status.lives", status.lives, lives);
        check_value("status.over", status.over, over);
        if (over != 0)
        begin
            for (int i = 0; i < 8; i++)
                check_value($sformatf("HEX%0d", i), hx[i], SEG_OVER[i]);
        end
        else
        begin
            check_value("HEX0 digit", seg_digit(HEX0), lives);
            for (int i = 1; i < 4; i++)
                check_value($sformatf("HEX%0d", i), hx[i], 7'h7f);
        end
    endtask

    task automatic check_score(input int score, input int high);
        check_value("HEX4 digit", seg_digit(HEX4), score % 16);
        check_value("HEX5 digit", seg_digit(HEX5), score / 16);
        check_value("HEX6 digit", seg_digit(HEX6), high % 16);
        check_value("HEX7 digit", seg_digit(HEX7), high / 16);
    endtask

    // Parks the player on bee 0's future path, then waits for the bee to pass
    task automatic bee_encounter(input logic enabled);
        point_t fut_pos;
        dir_t   fut_dir;
        point_t target;
        logic   found;
        logic   near;
        int     budget;
        int     c;
        logic [3:0] k;
        fut_pos = m_bee_pos[0];
        fut_dir = m_bee_dir[0];
        found = 1'b0;
        for (int t = 1; t <= 600 && !found; t++)
        begin
            fut_dir = model_turn(fut_pos, fut_dir);
            fut_pos = model_move(fut_pos, fut_dir);
            if (t >= 120 && fut_pos.x >= 8 && fut_pos.x <= 148
                && fut_pos.y >= 28 && fut_pos.y <= 108)
            begin
                found = 1'b1;
                target = fut_pos;
            end
        end
        if (!found)
        begin
            $display("No meeting point with bee 0 could be found");
            errors++;
            return;
        end
        budget = 0;
        while (exp_player != target && budget < 200)
        begin
            k = 4'b1111;
            if (target.x > exp_player.x)
                k[0] = 1'b0;
            else if (target.x < exp_player.x)
                k[3] = 1'b0;
            if (target.y > exp_player.y)
                k[2] = 1'b0;
            else if (target.y < exp_player.y)
                k[1] = 1'b0;
            KEY = k;
            SW = 18'h0;
            wait_one_tick(c);
            exp_player = player_step(exp_player, k);
            budget++;
        end
        KEY = 4'b1111;
        SW = enabled ? 18'h00001 : 18'h00000;
        near = 1'b0;
        budget = 0;
        while (!near && budget < 700)
        begin
            near = within_radius(m_bee_pos[0], exp_player);
            wait_one_tick(c);
            budget++;
        end
        if (!near)
        begin
            $display("Bee 0 never came within range of the player");
            errors++;
        end
        else if (enabled)
        begin
            exp_lives--;
            exp_player = PLAYER_START;
        end
        @(negedge CLOCK_50);
        check_state(exp_player.x, exp_player.y, exp_lives, 0);
    endtask

    initial
    begin
        CLOCK_50 = 1'b0;
        rst_n = 1'b0;
        KEY = 4'b1111;
        SW = 18'h0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        rng = 32'd72914;
        for (int i = 0; i < NUM_BEES; i++)
        begin
            m_bee_pos[i] = BEE_START_POS[i];
            m_bee_dir[i] = BEE_START_DIR[i];
        end
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        rst_n = 1'b1;

        for (int s = 0; s < NUM_STEPS; s++)
        begin
            start_err = errors;
            KEY = STEPS[s].key;
            SW = STEPS[s].sw;
            repeat (STEPS[s].ticks) wait_one_tick(cycles);
            // One more cycle so the high score has settled
            @(negedge CLOCK_50);
            check_state(STEPS[s].x, STEPS[s].y, STEPS[s].lives, STEPS[s].over);
            if (STEPS[s].over == 0)
                check_score(STEPS[s].score, STEPS[s].high);
            finish_test($sformatf("table step %0d", s), start_err);
        end

        exp_player.x = coord_x_t'(STEPS[NUM_STEPS-1].x);
        exp_player.y = coord_y_t'(STEPS[NUM_STEPS-1].y);
        exp_lives = STEPS[NUM_STEPS-1].lives;

        // Short walk stays well clear of the borders
        start_err = errors;
        for (int r = 0; r < 10; r++)
        begin
            rng = xorshift(rng);
            keys = rng[3:0];
            KEY = keys;
            repeat (2)
            begin
                wait_one_tick(cycles);
                exp_player = player_step(exp_player, keys);
            end
            check_state(exp_player.x, exp_player.y, exp_lives, 0);
        end
        finish_test("random walk", start_err);

        start_err = errors;
        bee_encounter(1'b1);
        finish_test("enabled bee hit", start_err);

        start_err = errors;
        bee_encounter(1'b0);
        finish_test("disabled bee pass", start_err);

        for (int s = 0; s < 4; s++)
        begin
            start_err = errors;
            KEY = 4'b1111;
            SW = {2'(s), 16'h0};
            // First interval may still use the old period
            wait_one_tick(cycles);
            repeat (2)
            begin
                wait_one_tick(cycles);
                check_value("tick spacing", cycles, TICK_PERIODS[s]);
            end
            finish_test($sformatf("speed select %0d", s), start_err);
        end

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests, failed_tests, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+testbench
rtl/bounce_pkg.sv
rtl/game_tick.sv
rtl/control_decode.sv
rtl/sprite_motion.sv
rtl/hit_and_lives.sv
rtl/scoreboard_display.sv
rtl/bounce_top.sv
testbench/bounce_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module bounce_tb -f project.f -o bounce_sim \
    && ./obj_dir/bounce_sim > sim.log 2>&1 \
    || { echo "Build or simulation run error"; exit 1; }
cat sim.log
grep -q "=== PASS ===" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
